//--- verilog/mem_gate_consts.svh
/* mem gate constants
   table geometry, request field widths and entry field widths */
`ifndef MEM_GATE_CONSTS_SVH
`define MEM_GATE_CONSTS_SVH

// ============================================================
// page table geometry
// ============================================================
`define MG_PAGES    64        // entries in the page table
`define MG_PAGE_W   6         // page index width
`define MG_PAGE_LSB 16        // 64 kB pages

// ============================================================
// request fields
// ============================================================
`define MG_ADDR_W   32        // request address
`define MG_DATA_W   32        // request write data
`define MG_TID_W    8         // transaction id

// ============================================================
// entry fields
// ============================================================
`define MG_KEY_W    23        // protection key
`define MG_PL_W     8         // privilege level, 0 means open
`define MG_CNT_W    27        // saturating access count

`endif

//--- verilog/mem_gate_pkg.sv
/* mem gate types
   enums for segments, response codes, table ops and lookup kinds */
`include "mem_gate_consts.svh"

package mem_gate_pkg;

  // segment a request is issued from
  typedef enum logic [1:0] {
    SEG_CODE  = 2'd0,
    SEG_DATA  = 2'd1,
    SEG_STACK = 2'd2
  } seg_e;

  typedef enum logic [1:0] {
    ERR_OKAY    = 2'd0,
    ERR_PROTERR = 2'd1     // key or privilege check failed
  } err_e;

  // table port command
  typedef enum logic [1:0] {
    TBL_NOP   = 2'd0,
    TBL_WRITE = 2'd1,
    TBL_READ  = 2'd2
  } tbl_op_e;

  // what owns the RAM read in stage 1
  typedef enum logic [2:0] {
    LK_NONE   = 3'd0,
    LK_REQ    = 3'd1,
    LK_SWEEP  = 3'd2,
    LK_TBL_WR = 3'd3,
    LK_TBL_RD = 3'd4
  } lookup_e;

  // one page table entry, 60 bits
  typedef struct packed {
    logic                 code;   // 1 = code area
    logic [`MG_KEY_W-1:0] key;
    logic [`MG_PL_W-1:0]  pl;
    logic                 refd;   // referenced since last table write
    logic [`MG_CNT_W-1:0] cnt;
  } page_entry_t;

endpackage

//--- verilog/page_table_ram.sv
/* page table RAM
   simple dual port entry store, one cycle read, pending write bypassed */
`timescale 1ns/100ps
`include "mem_gate_consts.svh"

module page_table_ram
  import mem_gate_pkg::*;
(
  input  logic                  clk,
  input  logic [`MG_PAGE_W-1:0] rd_idx_i,    // read port index
  input  logic                  wr_en_i,     // write back strobe
  input  logic [`MG_PAGE_W-1:0] wr_idx_i,
  input  page_entry_t           wr_entry_i,
  output page_entry_t           rd_entry_o   // valid one cycle after rd_idx_i
);

  page_entry_t mem [`MG_PAGES];

  logic bypass;   // read hits the entry being written this cycle

  // power-up contents all zero, same as a block RAM init value
  initial begin
    for (int i = 0; i < `MG_PAGES; i++) begin
      mem[i] = '0;
    end
  end

  // ============================================================
  // write port
  // ============================================================
  always_ff @(posedge clk) begin
    if (wr_en_i)
      mem[wr_idx_i] <= wr_entry_i;
  end

  // ============================================================
  // read port
  // ============================================================
  assign bypass = wr_en_i && (wr_idx_i == rd_idx_i);

  // forward the new entry so back to back lookups see the update
  always_ff @(posedge clk) begin
    if (bypass)
      rd_entry_o <= wr_entry_i;
    else
      rd_entry_o <= mem[rd_idx_i];
  end

endmodule

//--- verilog/page_table_regs.sv
/* page table control
   read port arbitration, aging sweep pointer and table port response */
`timescale 1ns/100ps
`include "mem_gate_consts.svh"

module page_table_regs
  import mem_gate_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  age_i,        // restart the halving sweep
  input  logic                  req_valid_i,
  input  logic [`MG_PAGE_W-1:0] req_page_i,
  input  tbl_op_e               tbl_op_i,
  input  logic [`MG_PAGE_W-1:0] tbl_idx_i,
  input  logic                  tbl_code_i,
  input  logic [`MG_KEY_W-1:0]  tbl_key_i,
  input  logic [`MG_PL_W-1:0]   tbl_pl_i,
  output logic [`MG_PAGE_W-1:0] rd_idx_o,     // RAM read index, combinational
  output lookup_e               lk_kind_o,    // stage 1 kind
  output logic [`MG_PAGE_W-1:0] lk_idx_o,     // stage 1 index
  output page_entry_t           lk_new_o,     // stage 1 table write value
  input  page_entry_t           rd_entry_i,   // stage 1 entry from RAM
  output logic                  tbl_rvalid_o,
  output logic                  tbl_code_o,
  output logic [`MG_KEY_W-1:0]  tbl_key_o,
  output logic [`MG_PL_W-1:0]   tbl_pl_o,
  output logic                  tbl_ref_o,
  output logic [`MG_CNT_W-1:0]  tbl_cnt_o
);

  logic [`MG_PAGE_W:0] sweep_ptr;   // MG_PAGES means stopped
  logic                sweep_run;
  lookup_e             kind_nxt;

  assign sweep_run = (sweep_ptr < (`MG_PAGE_W+1)'(`MG_PAGES));

  // ============================================================
  // read port priority
  // ============================================================
  always_comb begin
    kind_nxt = LK_NONE;
    rd_idx_o = sweep_ptr[`MG_PAGE_W-1:0];   // don't care when idle
    case (tbl_op_i)
      TBL_WRITE: begin
        kind_nxt = LK_TBL_WR;
        rd_idx_o = tbl_idx_i;
      end
      TBL_READ: begin
        kind_nxt = LK_TBL_RD;
        rd_idx_o = tbl_idx_i;
      end
      default: begin
        if (req_valid_i) begin
          kind_nxt = LK_REQ;
          rd_idx_o = req_page_i;
        end else if (sweep_run) begin
          kind_nxt = LK_SWEEP;              // idle slot goes to aging
        end
      end
    endcase
  end

  // sweep pointer only moves when it owns the read port
  always_ff @(posedge clk) begin
    if (rst)
      sweep_ptr <= (`MG_PAGE_W+1)'(`MG_PAGES);
    else if (age_i)
      sweep_ptr <= '0;
    else if (kind_nxt == LK_SWEEP)
      sweep_ptr <= sweep_ptr + 1'b1;
  end

  // ============================================================
  // stage 1 registers, alongside the RAM read
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst)
      lk_kind_o <= LK_NONE;
    else
      lk_kind_o <= kind_nxt;
  end

  always_ff @(posedge clk) begin
    lk_idx_o <= rd_idx_o;
    if (tbl_op_i == TBL_WRITE)
      lk_new_o <= '{code: tbl_code_i, key: tbl_key_i, pl: tbl_pl_i, refd: 1'b0, cnt: '0};
  end

  // ============================================================
  // table read response
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst)
      tbl_rvalid_o <= 1'b0;
    else
      tbl_rvalid_o <= (lk_kind_o == LK_TBL_RD);
  end

  always_ff @(posedge clk) begin
    if (lk_kind_o == LK_TBL_RD) begin
      tbl_code_o <= rd_entry_i.code;
      tbl_key_o  <= rd_entry_i.key;
      tbl_pl_o   <= rd_entry_i.pl;
      tbl_ref_o  <= rd_entry_i.refd;
      tbl_cnt_o  <= rd_entry_i.cnt;
    end
  end

endmodule

//--- verilog/access_checker.sv
/* access checker
   key and privilege test per request, forward or error strobe, entry write back */
`timescale 1ns/100ps
`include "mem_gate_consts.svh"

module access_checker
  import mem_gate_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  // request side, same cycle as the RAM read
  input  logic                  req_valid_i,
  input  logic [`MG_ADDR_W-1:0] req_adr_i,
  input  logic                  req_we_i,
  input  logic [`MG_PL_W-1:0]   req_pl_i,
  input  logic [`MG_KEY_W-1:0]  req_key_i,
  input  seg_e                  req_seg_i,
  input  logic [`MG_TID_W-1:0]  req_tid_i,
  input  logic [`MG_DATA_W-1:0] req_dat_i,
  // stage 1 lookup
  input  lookup_e               lk_kind_i,
  input  logic [`MG_PAGE_W-1:0] lk_idx_i,
  input  page_entry_t           lk_new_i,
  input  page_entry_t           rd_entry_i,
  // write back to the RAM
  output logic                  wr_en_o,
  output logic [`MG_PAGE_W-1:0] wr_idx_o,
  output page_entry_t           wr_entry_o,
  // forward port
  output logic                  fwd_valid_o,
  output logic [`MG_ADDR_W-1:0] fwd_adr_o,
  output logic                  fwd_we_o,
  output logic [`MG_TID_W-1:0]  fwd_tid_o,
  output logic [`MG_DATA_W-1:0] fwd_dat_o,
  // error response back to the requester
  output logic                  err_valid_o,
  output logic [`MG_TID_W-1:0]  err_tid_o,
  output logic [`MG_ADDR_W-1:0] err_adr_o,
  output err_e                  err_code_o
);

  // stage 1 copy of the request
  logic [`MG_ADDR_W-1:0] s1_adr;
  logic                  s1_we;
  logic [`MG_PL_W-1:0]   s1_pl;
  logic [`MG_KEY_W-1:0]  s1_key;
  seg_e                  s1_seg;
  logic [`MG_TID_W-1:0]  s1_tid;
  logic [`MG_DATA_W-1:0] s1_dat;

  logic                  s1_req;     // stage 1 holds a request
  logic                  key_ok;
  logic                  pl_open;    // entry pl 0 lets any level in
  logic                  priv_ok;
  logic                  pass;
  logic [`MG_CNT_W-1:0]  cnt_inc;    // saturating count + 1

  // ============================================================
  // request delay, one stage to line up with the entry
  // ============================================================
  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      s1_adr <= req_adr_i;
      s1_we  <= req_we_i;
      s1_pl  <= req_pl_i;
      s1_key <= req_key_i;
      s1_seg <= req_seg_i;
      s1_tid <= req_tid_i;
      s1_dat <= req_dat_i;
    end
  end

  assign s1_req = (lk_kind_i == LK_REQ);

  // ============================================================
  // permission rule
  // ============================================================
  assign key_ok  = (s1_key == rd_entry_i.key);
  assign pl_open = (rd_entry_i.pl == '0);

  always_comb begin
    if (rd_entry_i.code)   // code area, conforming or exact level
      priv_ok = (pl_open || rd_entry_i.pl == s1_pl) && (s1_seg == SEG_CODE);
    else                   // data area, level at least the entry's
      priv_ok = (pl_open || rd_entry_i.pl <= s1_pl) && (s1_seg != SEG_CODE);
  end

  assign pass = key_ok && priv_ok;

  // ============================================================
  // entry write back, lands on the RAM one cycle after the read
  // ============================================================
  assign cnt_inc = (&rd_entry_i.cnt) ? rd_entry_i.cnt : rd_entry_i.cnt + 1'b1;

  always_comb begin
    wr_en_o    = 1'b0;
    wr_entry_o = rd_entry_i;
    case (lk_kind_i)
      LK_REQ: begin                     // every lookup counts, pass or fail
        wr_en_o         = 1'b1;
        wr_entry_o.refd = 1'b1;
        wr_entry_o.cnt  = cnt_inc;
      end
      LK_SWEEP: begin
        wr_en_o        = 1'b1;
        wr_entry_o.cnt = rd_entry_i.cnt >> 1;   // ref kept
      end
      LK_TBL_WR: begin
        wr_en_o    = 1'b1;
        wr_entry_o = lk_new_i;          // ref and cnt already cleared
      end
      default: ;
    endcase
  end

  assign wr_idx_o = lk_idx_i;

  // ============================================================
  // forward and error strobes
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      fwd_valid_o <= 1'b0;
      err_valid_o <= 1'b0;
    end else begin
      fwd_valid_o <= s1_req && pass;
      err_valid_o <= s1_req && !pass;
    end
  end

  // payload follows the strobe, held between requests
  always_ff @(posedge clk) begin
    if (s1_req) begin
      fwd_adr_o  <= s1_adr;
      fwd_we_o   <= s1_we;
      fwd_tid_o  <= s1_tid;
      fwd_dat_o  <= s1_dat;
      err_tid_o  <= s1_tid;
      err_adr_o  <= s1_adr;
      err_code_o <= pass ? ERR_OKAY : ERR_PROTERR;
    end
  end

endmodule

//--- verilog/mem_gate.sv
/* memory access gate top
   page table lookup, protection check and access counting in front of memory */
`timescale 1ns/100ps
`include "mem_gate_consts.svh"

module mem_gate
  import mem_gate_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  age_i,
  // request in
  input  logic                  req_valid_i,
  input  logic [`MG_ADDR_W-1:0] req_adr_i,
  input  logic                  req_we_i,
  input  logic [`MG_PL_W-1:0]   req_pl_i,
  input  logic [`MG_KEY_W-1:0]  req_key_i,
  input  seg_e                  req_seg_i,
  input  logic [`MG_TID_W-1:0]  req_tid_i,
  input  logic [`MG_DATA_W-1:0] req_dat_i,
  // table port
  input  tbl_op_e               tbl_op_i,
  input  logic [`MG_PAGE_W-1:0] tbl_idx_i,
  input  logic                  tbl_code_i,
  input  logic [`MG_KEY_W-1:0]  tbl_key_i,
  input  logic [`MG_PL_W-1:0]   tbl_pl_i,
  output logic                  tbl_rvalid_o,
  output logic                  tbl_code_o,
  output logic [`MG_KEY_W-1:0]  tbl_key_o,
  output logic [`MG_PL_W-1:0]   tbl_pl_o,
  output logic                  tbl_ref_o,
  output logic [`MG_CNT_W-1:0]  tbl_cnt_o,
  // forward out
  output logic                  fwd_valid_o,
  output logic [`MG_ADDR_W-1:0] fwd_adr_o,
  output logic                  fwd_we_o,
  output logic [`MG_TID_W-1:0]  fwd_tid_o,
  output logic [`MG_DATA_W-1:0] fwd_dat_o,
  // protection error back
  output logic                  err_valid_o,
  output logic [`MG_TID_W-1:0]  err_tid_o,
  output logic [`MG_ADDR_W-1:0] err_adr_o,
  output err_e                  err_code_o
);

  logic [`MG_PAGE_W-1:0] rd_idx;
  lookup_e               lk_kind;
  logic [`MG_PAGE_W-1:0] lk_idx;
  page_entry_t           lk_new;
  page_entry_t           rd_entry;   // stage 1 entry, bypassed
  logic                  wr_en;
  logic [`MG_PAGE_W-1:0] wr_idx;
  page_entry_t           wr_entry;

  page_table_ram u_ram (
    .clk        (clk),
    .rd_idx_i   (rd_idx),
    .wr_en_i    (wr_en),
    .wr_idx_i   (wr_idx),
    .wr_entry_i (wr_entry),
    .rd_entry_o (rd_entry)
  );

  page_table_regs u_regs (
    .clk          (clk),
    .rst          (rst),
    .age_i        (age_i),
    .req_valid_i  (req_valid_i),
    .req_page_i   (req_adr_i[`MG_PAGE_LSB +: `MG_PAGE_W]),   // 64 kB page index
    .tbl_op_i     (tbl_op_i),
    .tbl_idx_i    (tbl_idx_i),
    .tbl_code_i   (tbl_code_i),
    .tbl_key_i    (tbl_key_i),
    .tbl_pl_i     (tbl_pl_i),
    .rd_idx_o     (rd_idx),
    .lk_kind_o    (lk_kind),
    .lk_idx_o     (lk_idx),
    .lk_new_o     (lk_new),
    .rd_entry_i   (rd_entry),
    .tbl_rvalid_o (tbl_rvalid_o),
    .tbl_code_o   (tbl_code_o),
    .tbl_key_o    (tbl_key_o),
    .tbl_pl_o     (tbl_pl_o),
    .tbl_ref_o    (tbl_ref_o),
    .tbl_cnt_o    (tbl_cnt_o)
  );

  access_checker u_chk (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_valid_i),
    .req_adr_i   (req_adr_i),
    .req_we_i    (req_we_i),
    .req_pl_i    (req_pl_i),
    .req_key_i   (req_key_i),
    .req_seg_i   (req_seg_i),
    .req_tid_i   (req_tid_i),
    .req_dat_i   (req_dat_i),
    .lk_kind_i   (lk_kind),
    .lk_idx_i    (lk_idx),
    .lk_new_i    (lk_new),
    .rd_entry_i  (rd_entry),
    .wr_en_o     (wr_en),
    .wr_idx_o    (wr_idx),
    .wr_entry_o  (wr_entry),
    .fwd_valid_o (fwd_valid_o),
    .fwd_adr_o   (fwd_adr_o),
    .fwd_we_o    (fwd_we_o),
    .fwd_tid_o   (fwd_tid_o),
    .fwd_dat_o   (fwd_dat_o),
    .err_valid_o (err_valid_o),
    .err_tid_o   (err_tid_o),
    .err_adr_o   (err_adr_o),
    .err_code_o  (err_code_o)
  );

endmodule

//--- verif/mem_gate_props.sv
/* mem gate properties
   request, response and reset rules, bound to the top level */
`timescale 1ns/100ps

module mem_gate_props
  import mem_gate_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    req_valid_i,
  input  tbl_op_e tbl_op_i,
  input  logic    fwd_valid_i,
  input  logic    err_valid_i,
  input  logic    tbl_rvalid_i
);

  int unsigned fail_cnt;   // read by the testbench at the end

  // requests and table ops share one read slot
  no_req_in_tbl_op: assert property (@(posedge clk) disable iff (rst)
    req_valid_i |-> (tbl_op_i == TBL_NOP))
  else begin
    fail_cnt++;
    $error("request strobe during a table operation");
  end

  fwd_err_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(fwd_valid_i && err_valid_i))
  else begin
    fail_cnt++;
    $error("forward and error strobes high together");
  end

  // ============================================================
  // reset and response timing
  // ============================================================
  quiet_after_reset: assert property (@(posedge clk)
    rst |=> !(fwd_valid_i || err_valid_i || tbl_rvalid_i))
  else begin
    fail_cnt++;
    $error("output strobe high in the cycle after reset");
  end

  one_response: assert property (@(posedge clk) disable iff (rst)
    $past(req_valid_i, 2) |-> (fwd_valid_i ^ err_valid_i))
  else begin
    fail_cnt++;
    $error("request not answered by exactly one strobe two cycles later");
  end

endmodule

bind mem_gate mem_gate_props props_i (
  .clk          (clk),
  .rst          (rst),
  .req_valid_i  (req_valid_i),
  .tbl_op_i     (tbl_op_i),
  .fwd_valid_i  (fwd_valid_o),
  .err_valid_i  (err_valid_o),
  .tbl_rvalid_i (tbl_rvalid_o)
);

//--- verif/mem_gate_checker.sv
/* mem gate scoreboard
   compares forward, error and table read strobes with the expected queues */
`timescale 1ns/100ps
`include "mem_gate_consts.svh"

module mem_gate_checker
  import mem_gate_pkg::*;
(
  input  logic                  clk,
  input  int unsigned           cycle_i,      // negedge count from the testbench
  input  logic                  fwd_valid_i,
  input  logic [`MG_ADDR_W-1:0] fwd_adr_i,
  input  logic                  fwd_we_i,
  input  logic [`MG_TID_W-1:0]  fwd_tid_i,
  input  logic [`MG_DATA_W-1:0] fwd_dat_i,
  input  logic                  err_valid_i,
  input  logic [`MG_TID_W-1:0]  err_tid_i,
  input  logic [`MG_ADDR_W-1:0] err_adr_i,
  input  err_e                  err_code_i,
  input  logic                  tbl_rvalid_i,
  input  logic                  tbl_code_i,
  input  logic [`MG_KEY_W-1:0]  tbl_key_i,
  input  logic [`MG_PL_W-1:0]   tbl_pl_i,
  input  logic                  tbl_ref_i,
  input  logic [`MG_CNT_W-1:0]  tbl_cnt_i,
  output int unsigned           value_errs_o,
  output int unsigned           missing_o,
  output int unsigned           unexpected_o
);

  // port 0 forward {adr,we,tid,dat}, 1 error {tid,adr,code}, 2 table read entry
  logic [127:0] exp_q [3][$];
  int unsigned  due_q [3][$];   // cycle each expected strobe is seen at negedge

  task automatic forward_expected(input int unsigned due, input logic [`MG_ADDR_W-1:0] adr,
                                  input logic we, input logic [`MG_TID_W-1:0] tid,
                                  input logic [`MG_DATA_W-1:0] dat);
    exp_q[0].push_back(128'({adr, we, tid, dat}));
    due_q[0].push_back(due);
  endtask

  task automatic error_expected(input int unsigned due, input logic [`MG_TID_W-1:0] tid,
                                input logic [`MG_ADDR_W-1:0] adr);
    exp_q[1].push_back(128'({tid, adr, ERR_PROTERR}));
    due_q[1].push_back(due);
  endtask

  task automatic readback_expected(input int unsigned due, input page_entry_t e);
    exp_q[2].push_back(128'(e));
    due_q[2].push_back(due);
  endtask

  function automatic int pending();
    return due_q[0].size() + due_q[1].size() + due_q[2].size();
  endfunction

  // ============================================================
  // one strobe port, in order, against its queue head
  // ============================================================
  task automatic score_port(input int p, input string name, input logic valid,
                            input logic [127:0] got);
    logic [127:0] want;
    int unsigned  due;
    if (valid) begin
      if (due_q[p].size() == 0 || due_q[p][0] != cycle_i) begin
        unexpected_o++;
        $display("ERROR @%0t: %s strobe with nothing due in this cycle", $time, name);
      end else begin
        want = exp_q[p].pop_front();
        due  = due_q[p].pop_front();
        if (got !== want) begin
          value_errs_o++;
          $display("ERROR @%0t: %s got %h expected %h", $time, name, got, want);
        end
      end
    end else if (due_q[p].size() != 0 && due_q[p][0] <= cycle_i) begin
      want = exp_q[p].pop_front();   // strobe never came, drop it
      due  = due_q[p].pop_front();
      missing_o++;
      $display("ERROR @%0t: %s strobe due in cycle %0d did not arrive, expected %h",
               $time, name, due, want);
    end
  endtask

  // outputs settle after the rising edge, sampled half a cycle later
  always @(negedge clk) begin
    score_port(0, "forward", fwd_valid_i,
               128'({fwd_adr_i, fwd_we_i, fwd_tid_i, fwd_dat_i}));
    score_port(1, "error", err_valid_i, 128'({err_tid_i, err_adr_i, err_code_i}));
    score_port(2, "table read", tbl_rvalid_i,
               128'({tbl_code_i, tbl_key_i, tbl_pl_i, tbl_ref_i, tbl_cnt_i}));
  end

endmodule

//--- verif/mem_gate_tb.sv
/* mem gate testbench
   table driven stimulus and a page table model feeding the scoreboard */
`timescale 1ns/100ps
`include "mem_gate_consts.svh"

module mem_gate_tb
  import mem_gate_pkg::*;
();

  typedef enum logic [1:0] {
    OP_WR,    // table write
    OP_RD,    // table read
    OP_REQ,   // memory request
    OP_AGE    // age pulse then idle while the sweep runs
  } row_op_e;

  typedef struct packed {
    row_op_e                 op;
    logic [`MG_PAGE_W-1:0]   page;
    logic [`MG_PAGE_LSB-1:0] off;    // byte offset inside the page
    logic                    code;
    logic [`MG_KEY_W-1:0]    key;
    logic [`MG_PL_W-1:0]     pl;
    seg_e                    seg;
    logic                    we;
  } stim_row_t;

  logic clk = 1'b0;
  logic rst;
  logic age_i;
  logic req_valid_i, req_we_i;
  logic [`MG_ADDR_W-1:0] req_adr_i;
  logic [`MG_PL_W-1:0]   req_pl_i;
  logic [`MG_KEY_W-1:0]  req_key_i;
  seg_e                  req_seg_i;
  logic [`MG_TID_W-1:0]  req_tid_i;
  logic [`MG_DATA_W-1:0] req_dat_i;
  tbl_op_e               tbl_op_i;
  logic [`MG_PAGE_W-1:0] tbl_idx_i;
  logic                  tbl_code_i;
  logic [`MG_KEY_W-1:0]  tbl_key_i;
  logic [`MG_PL_W-1:0]   tbl_pl_i;
  logic                  tbl_rvalid_o, tbl_code_o, tbl_ref_o;
  logic [`MG_KEY_W-1:0]  tbl_key_o;
  logic [`MG_PL_W-1:0]   tbl_pl_o;
  logic [`MG_CNT_W-1:0]  tbl_cnt_o;
  logic                  fwd_valid_o, fwd_we_o, err_valid_o;
  logic [`MG_ADDR_W-1:0] fwd_adr_o, err_adr_o;
  logic [`MG_TID_W-1:0]  fwd_tid_o, err_tid_o;
  logic [`MG_DATA_W-1:0] fwd_dat_o;
  err_e                  err_code_o;

  stim_row_t   rows [$];
  page_entry_t model [`MG_PAGES];     // expected table contents
  int unsigned cycle;                 // negedge count shared with the scoreboard
  int unsigned limit;                 // timeout limit stays 0 until the table is built
  int unsigned value_errs, missing, unexpected, total;

  always #5 clk = ~clk;

  mem_gate dut_i (.*);

  mem_gate_checker chk_i (
    .clk (clk), .cycle_i (cycle),
    .fwd_valid_i (fwd_valid_o), .fwd_adr_i (fwd_adr_o), .fwd_we_i (fwd_we_o),
    .fwd_tid_i (fwd_tid_o), .fwd_dat_i (fwd_dat_o),
    .err_valid_i (err_valid_o), .err_tid_i (err_tid_o), .err_adr_i (err_adr_o),
    .err_code_i (err_code_o),
    .tbl_rvalid_i (tbl_rvalid_o), .tbl_code_i (tbl_code_o), .tbl_key_i (tbl_key_o),
    .tbl_pl_i (tbl_pl_o), .tbl_ref_i (tbl_ref_o), .tbl_cnt_i (tbl_cnt_o),
    .value_errs_o (value_errs), .missing_o (missing), .unexpected_o (unexpected)
  );

  // watchdog
  always @(negedge clk) begin
    cycle <= cycle + 1;
    if (limit != 0 && cycle >= limit) begin
      $display("timeout: run still busy after %0d cycles", cycle);
      $display("TB FAILED");
      $finish;
    end
  end

  // ============================================================
  // reference model from the access rules
  // ============================================================
  function automatic logic permitted(input page_entry_t e, input logic [`MG_PL_W-1:0] pl,
                                     input logic [`MG_KEY_W-1:0] key, input seg_e seg);
    logic fits;
    if (e.code)
      fits = (e.pl == 0 || e.pl == pl) && seg == SEG_CODE;   // code area needs the exact level
    else
      fits = (e.pl == 0 || e.pl <= pl) && seg != SEG_CODE;   // data area takes that level or above
    return fits && key == e.key;
  endfunction

  function automatic void count_access(input logic [`MG_PAGE_W-1:0] p);
    model[p].refd = 1'b1;
    if (model[p].cnt != '1)
      model[p].cnt = model[p].cnt + 1'b1;   // saturates
  endfunction

  // ============================================================
  // stimulus table
  // ============================================================
  task automatic write_entry(input logic [`MG_PAGE_W-1:0] p, input logic c,
                             input logic [`MG_KEY_W-1:0] k, input logic [`MG_PL_W-1:0] l);
    rows.push_back('{op: OP_WR, page: p, off: '0, code: c, key: k, pl: l,
                     seg: SEG_DATA, we: 1'b0});
  endtask

  task automatic read_entry(input logic [`MG_PAGE_W-1:0] p);
    rows.push_back('{op: OP_RD, page: p, off: '0, code: 1'b0, key: '0, pl: '0,
                     seg: SEG_DATA, we: 1'b0});
  endtask

  task automatic access_page(input logic [`MG_PAGE_W-1:0] p,
                             input logic [`MG_PAGE_LSB-1:0] o, input logic w,
                             input logic [`MG_PL_W-1:0] l, input logic [`MG_KEY_W-1:0] k,
                             input seg_e s);
    rows.push_back('{op: OP_REQ, page: p, off: o, code: 1'b0, key: k, pl: l, seg: s, we: w});
  endtask

  task automatic start_aging();
    rows.push_back('{op: OP_AGE, page: '0, off: '0, code: 1'b0, key: '0, pl: '0,
                     seg: SEG_DATA, we: 1'b0});
  endtask

  task automatic build_stimulus();
    write_entry(6'd1, 1'b1, 23'h012345, 8'd3);   // code area at exact level 3
    write_entry(6'd2, 1'b1, 23'h00abcd, 8'd0);   // code area open to all levels
    write_entry(6'd3, 1'b0, 23'h07fff0, 8'd2);   // data area for level 2 and up
    write_entry(6'd4, 1'b0, 23'h000042, 8'd0);   // open data area
    write_entry(6'd5, 1'b0, 23'h555555, 8'd5);
    for (int p = 1; p <= 5; p++)
      read_entry(6'(p));
    // passing requests
    access_page(6'd1, 16'h0010, 1'b0, 8'd3, 23'h012345, SEG_CODE);
    access_page(6'd2, 16'hfffc, 1'b0, 8'd7, 23'h00abcd, SEG_CODE);
    access_page(6'd3, 16'h1234, 1'b1, 8'd2, 23'h07fff0, SEG_DATA);
    access_page(6'd3, 16'h2000, 1'b1, 8'd6, 23'h07fff0, SEG_STACK);
    access_page(6'd4, 16'h0000, 1'b1, 8'd0, 23'h000042, SEG_DATA);
    // failing requests
    access_page(6'd1, 16'h0020, 1'b0, 8'd3, 23'h012346, SEG_CODE);   // wrong key
    access_page(6'd1, 16'h0024, 1'b0, 8'd4, 23'h012345, SEG_CODE);   // level above but not equal
    access_page(6'd1, 16'h0028, 1'b1, 8'd3, 23'h012345, SEG_DATA);   // data seg on code
    access_page(6'd3, 16'h3000, 1'b0, 8'd1, 23'h07fff0, SEG_DATA);   // level too low
    access_page(6'd3, 16'h3004, 1'b0, 8'd5, 23'h07fff0, SEG_CODE);   // code seg on data
    access_page(6'd4, 16'h0008, 1'b1, 8'd0, 23'h000043, SEG_DATA);   // wrong key
    // back to back on one page with mixed pass and fail
    access_page(6'd5, 16'h0100, 1'b1, 8'd5, 23'h555555, SEG_DATA);
    access_page(6'd5, 16'h0104, 1'b0, 8'd4, 23'h555555, SEG_DATA);
    access_page(6'd5, 16'h0108, 1'b1, 8'd9, 23'h555555, SEG_STACK);
    access_page(6'd5, 16'h010c, 1'b0, 8'd5, 23'h555555, SEG_CODE);
    read_entry(6'd5);                            // right behind the last write back
    for (int p = 1; p <= 5; p++)
      read_entry(6'(p));
    start_aging();
    for (int p = 0; p <= 5; p++)
      read_entry(6'(p));
    // rewrite of a used page drops its ref bit and count
    write_entry(6'd3, 1'b1, 23'h13579b, 8'd4);
    read_entry(6'd3);
  endtask

  task automatic drive_idle();
    req_valid_i <= 1'b0;
    tbl_op_i    <= TBL_NOP;
    age_i       <= 1'b0;
  endtask

  // called on a rising edge so the DUT samples at the next one
  task automatic apply_row(input stim_row_t r);
    logic [31:0]           rnd_tid, rnd_dat, rnd_hi;
    logic [`MG_ADDR_W-1:0] adr;
    int unsigned           due;
    due = cycle + 2;   // strobe seen at the negedge two edges on
    drive_idle();
    case (r.op)
      OP_WR: begin
        tbl_op_i   <= TBL_WRITE;
        tbl_idx_i  <= r.page;
        tbl_code_i <= r.code;
        tbl_key_i  <= r.key;
        tbl_pl_i   <= r.pl;
        model[r.page] = '{code: r.code, key: r.key, pl: r.pl, refd: 1'b0, cnt: '0};
      end
      OP_RD: begin
        tbl_op_i  <= TBL_READ;
        tbl_idx_i <= r.page;
        chk_i.readback_expected(due, model[r.page]);
      end
      OP_REQ: begin
        rnd_tid = $urandom();
        rnd_dat = $urandom();
        rnd_hi  = $urandom();
        adr = {rnd_hi[9:0], r.page, r.off};   // bits above the page index are ignored
        req_valid_i <= 1'b1;
        req_adr_i   <= adr;
        req_we_i    <= r.we;
        req_pl_i    <= r.pl;
        req_key_i   <= r.key;
        req_seg_i   <= r.seg;
        req_tid_i   <= rnd_tid[`MG_TID_W-1:0];
        req_dat_i   <= rnd_dat;
        if (permitted(model[r.page], r.pl, r.key, r.seg))
          chk_i.forward_expected(due, adr, r.we, rnd_tid[`MG_TID_W-1:0], rnd_dat);
        else
          chk_i.error_expected(due, rnd_tid[`MG_TID_W-1:0], adr);
        count_access(r.page);                 // counted pass or fail
      end
      default: begin
        age_i <= 1'b1;
        for (int i = 0; i < `MG_PAGES; i++)
          model[i].cnt = model[i].cnt >> 1;
      end
    endcase
  endtask

  initial begin
    void'($urandom(32'hcd49b1ea));
    for (int i = 0; i < `MG_PAGES; i++)
      model[i] = '0;
    rst = 1'b1;
    age_i = 1'b0;
    req_valid_i = 1'b0;
    req_adr_i = '0;
    req_we_i = 1'b0;
    req_pl_i = '0;
    req_key_i = '0;
    req_seg_i = SEG_CODE;
    req_tid_i = '0;
    req_dat_i = '0;
    tbl_op_i = TBL_NOP;
    tbl_idx_i = '0;
    tbl_code_i = 1'b0;
    tbl_key_i = '0;
    tbl_pl_i = '0;
    build_stimulus();
    limit = rows.size() * 4 + `MG_PAGES * 2 + 50;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    foreach (rows[i]) begin
      @(posedge clk);
      apply_row(rows[i]);
      if (rows[i].op == OP_AGE) begin
        // idle slots let the sweep visit every entry
        repeat (`MG_PAGES + 4) begin
          @(posedge clk);
          drive_idle();
        end
      end
    end
    @(posedge clk);
    drive_idle();
    while (chk_i.pending() != 0)
      @(posedge clk);
    repeat (3) @(posedge clk);   // catch stray strobes
    total = value_errs + missing + unexpected + dut_i.props_i.fail_cnt;
    $display("errors: value %0d, missing %0d, unexpected %0d, assertion %0d",
             value_errs, missing, unexpected, dut_i.props_i.fail_cnt);
    if (total == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

//--- mem_gate.f
+incdir+verilog
verilog/mem_gate_pkg.sv
verilog/page_table_ram.sv
verilog/page_table_regs.sv
verilog/access_checker.sv
verilog/mem_gate.sv
verif/mem_gate_props.sv
verif/mem_gate_checker.sv
verif/mem_gate_tb.sv

//--- Makefile
# Verilator build and run for the memory access gate
# override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= mem_gate_tb
FLIST     ?= mem_gate.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TB PASSED

.PHONY: sim clean

# build, run, then look for the pass line in the simulator output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
